// File: src/trig_pkg.sv
package trig_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes shared by every block of the trigger path
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_TRIGGERS  = 4;   // sequenced trigger slots.
  localparam int NUM_PINS      = 3;   // digital pins that feed slots 0 to 2.
  localparam int COUNTER_WIDTH = 16;  // gap counter and window bound width.
  localparam int SLOT_WIDTH    = 2;   // enough to index NUM_TRIGGERS slots.
  localparam int ADC_WIDTH     = 12;  // one ADC sample.
  localparam int CAPTURE_LEN   = 64;  // capture window length in samples.
  localparam int COUNT_WIDTH   = 16;  // trigger counter width, it wraps.

  // the capture window counter must hold CAPTURE_LEN itself.
  localparam int CAPTURE_CNT_WIDTH = $clog2(CAPTURE_LEN + 1);

  ////////////////////////////////////////////////////////////////////////////
  // configuration and status bundles
  ////////////////////////////////////////////////////////////////////////////

  // sequencer setup. Gap g sits between slot g and slot g+1.
  typedef struct packed {
    logic                                         bypass;     // slot 0 goes straight out.
    logic [SLOT_WIDTH-1:0]                        last_slot;  // slot that completes a sequence.
    logic                                         enable;     // low parks the FSM in idle.
    logic [NUM_TRIGGERS-2:0][COUNTER_WIDTH-1:0]   min_wait;   // earliest accepted count per gap.
    logic [NUM_TRIGGERS-2:0][COUNTER_WIDTH-1:0]   max_wait;   // count that ends a gap as late.
  } seq_cfg_t;

  // level trigger setup.
  typedef struct packed {
    logic [ADC_WIDTH-1:0] threshold;  // compared against each sample.
    logic                 falling;    // set to fire on a downward crossing.
  } level_cfg_t;

  // status seen by the host side.
  typedef struct packed {
    logic armed;           // waiting for a trigger sequence.
    logic capture_active;  // capture window is open.
    logic fail_early;      // one-cycle pulse on a gap below min_wait.
    logic fail_late;       // one-cycle pulse on a gap that hit max_wait.
  } trig_status_t;

  ////////////////////////////////////////////////////////////////////////////
  // sequencer FSM encoding
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SEQ_IDLE       = 2'd0,  // not armed or not enabled.
    SEQ_WAIT_FIRST = 2'd1,  // looking for a slot 0 pulse.
    SEQ_WAIT_NEXT  = 2'd2   // timing the gap to the next slot.
  } seq_state_t;

endpackage

// File: src/trigger_pin_sync.sv
module trigger_pin_sync (
  input  logic                          adc_clk,
  input  logic                          rst,
  input  logic [trig_pkg::NUM_PINS-1:0] pins,
  output logic [trig_pkg::NUM_PINS-1:0] pin_edges
);

  import trig_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // synchronizer chain
  ////////////////////////////////////////////////////////////////////////////

  logic [NUM_PINS-1:0] sync_meta;  // first stage, the one that may go metastable.
  logic [NUM_PINS-1:0] sync_q;     // second stage, safe to use in adc_clk logic.
  logic [NUM_PINS-1:0] prev_q;     // last cycle's synchronized level.

  // the pins are asynchronous to adc_clk, so every bit gets its own two flops.
  always_ff @(posedge adc_clk) begin
    if (rst) begin
      sync_meta <= '0;  // all pins read as low after reset.
      sync_q    <= '0;
      prev_q    <= '0;
    end else begin
      sync_meta <= pins;    // capture the raw levels.
      sync_q    <= sync_meta;  // settle for one more cycle.
      prev_q    <= sync_q;  // remember the level for edge detection.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // rising edge pulse
  ////////////////////////////////////////////////////////////////////////////

  // a pulse is high for exactly one cycle, since prev_q catches up next cycle.
  always_ff @(posedge adc_clk) begin
    if (rst) begin
      pin_edges <= '0;  // no edge can be reported straight out of reset.
    end else begin
      pin_edges <= sync_q & ~prev_q;  // new high after low gives a pulse.
    end
  end

  // a pin that rises is seen by sync_meta first, then sync_q,
  // and the third flop in line is pin_edges itself.

endmodule

// File: src/adc_level_trigger.sv
module adc_level_trigger (
  input  logic                           adc_clk,
  input  logic                           rst,
  input  logic [trig_pkg::ADC_WIDTH-1:0] adc_data,
  input  trig_pkg::level_cfg_t           cfg,
  output logic                           level_edge
);

  ////////////////////////////////////////////////////////////////////////////
  // threshold compare
  ////////////////////////////////////////////////////////////////////////////

  logic hit;    // current sample is on the trigger side of the threshold.
  logic hit_q;  // same test on the previous sample.

  // both tests include equality, so a sample sitting on the threshold counts.
  always_comb begin
    if (cfg.falling) begin
      hit = (adc_data <= cfg.threshold);  // downward, at or below.
    end else begin
      hit = (adc_data >= cfg.threshold);  // upward, at or above.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // crossing detect
  ////////////////////////////////////////////////////////////////////////////

  // the pulse shows up one cycle after the sample that crossed.
  always_ff @(posedge adc_clk) begin
    if (rst) begin
      hit_q      <= 1'b1;  // taken as already crossed, so the first sample cannot fire.
      level_edge <= 1'b0;
    end else begin
      hit_q      <= hit;           // keep this sample's result for the next one.
      level_edge <= hit & ~hit_q;  // false to true is a crossing.
    end
  end

  // a polarity change flips the meaning of hit_q for one sample.
  // that may give a single pulse, which is a true crossing under the new test.

endmodule

// File: src/trigger_sequencer.sv
module trigger_sequencer (
  input  logic                              adc_clk,
  input  logic                              rst,
  input  logic                              armed,
  input  logic [trig_pkg::NUM_TRIGGERS-1:0] triggers,
  input  trig_pkg::seq_cfg_t                cfg,
  output logic                              trig_out,
  output logic                              fail_early,
  output logic                              fail_late
);

  import trig_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // state and gap timing
  ////////////////////////////////////////////////////////////////////////////

  seq_state_t               state;       // current FSM state.
  seq_state_t               next_state;  // FSM state for the next cycle.
  logic [SLOT_WIDTH-1:0]    slot;        // slot index we expect a pulse on.
  logic [SLOT_WIDTH-1:0]    gap;         // gap that ends on the expected slot.
  logic [COUNTER_WIDTH-1:0] counter;     // cycles since the slot advanced.
  logic [COUNTER_WIDTH-1:0] min_wait;    // lower window bound of this gap.
  logic [COUNTER_WIDTH-1:0] max_wait;    // upper window bound of this gap.
  logic                     go;          // armed and enabled.
  logic                     hit;         // pulse on the expected slot.
  logic                     advance;     // step to the next slot and restart the gap.
  logic                     seq_fire;    // last slot arrived inside its window.
  logic                     early;       // expected pulse came before min_wait.
  logic                     late;        // counter reached max_wait first.

  assign go  = armed & cfg.enable;  // either one low sends us to idle.
  assign hit = triggers[slot];      // other slots are simply ignored.

  // slot 0 has no gap before it, so clamp to gap 0 to stay in range.
  assign gap      = (slot == '0) ? '0 : slot - 1'b1;
  assign min_wait = cfg.min_wait[gap];
  assign max_wait = cfg.max_wait[gap];

  ////////////////////////////////////////////////////////////////////////////
  // next state logic
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state = state;  // hold unless something below moves us.
    advance    = 1'b0;
    seq_fire   = 1'b0;
    early      = 1'b0;
    late       = 1'b0;
    if (!go) begin
      next_state = SEQ_IDLE;  // nothing fires while not armed.
    end else begin
      case (state)
        SEQ_IDLE: begin
          next_state = SEQ_WAIT_FIRST;  // armed, start looking one cycle later.
        end
        SEQ_WAIT_FIRST: begin
          if (triggers[0]) begin
            if (cfg.last_slot == '0) begin
              seq_fire   = 1'b1;  // one-slot sequence is already complete.
              next_state = SEQ_IDLE;
            end else begin
              advance    = 1'b1;  // start timing gap 0.
              next_state = SEQ_WAIT_NEXT;
            end
          end
        end
        SEQ_WAIT_NEXT: begin
          if (hit) begin
            if (counter >= min_wait) begin
              if (slot >= cfg.last_slot) begin
                seq_fire   = 1'b1;  // final slot inside its window.
                next_state = SEQ_IDLE;
              end else begin
                advance = 1'b1;  // good pulse, move to the next gap.
              end
            end else begin
              early      = 1'b1;  // arrived too soon, abort.
              next_state = SEQ_IDLE;
            end
          end else if (counter == max_wait) begin
            late       = 1'b1;  // window ran out, abort.
            next_state = SEQ_IDLE;
          end
        end
        default: begin
          next_state = SEQ_IDLE;  // unused encoding recovers to idle.
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      state   <= SEQ_IDLE;
      slot    <= '0;
      counter <= '0;
    end else begin
      state <= next_state;
      if (state == SEQ_IDLE) begin
        slot <= '0;  // every sequence starts from slot 0.
      end else if (advance) begin
        slot <= slot + 1'b1;
      end
      if (advance) begin
        counter <= '0;  // zero in the first cycle after the advancing pulse.
      end else if (state == SEQ_WAIT_NEXT) begin
        counter <= counter + 1'b1;  // max_wait stops it before any wrap.
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  // the trigger leaves in the same cycle as the final pulse.
  assign trig_out = cfg.bypass ? triggers[0] : seq_fire;

  // in bypass the sequence result is discarded, and so are its failures.
  assign fail_early = early & ~cfg.bypass;
  assign fail_late  = late & ~cfg.bypass;

endmodule

// File: src/capture_arm_ctrl.sv
module capture_arm_ctrl (
  input  logic                             adc_clk,
  input  logic                             rst,
  input  logic                             arm,
  input  logic                             disarm,
  input  logic                             trig_in,
  output logic                             armed,
  output logic                             capture_active,
  output logic [trig_pkg::COUNT_WIDTH-1:0] trig_count
);

  import trig_pkg::*;

  logic [CAPTURE_CNT_WIDTH-1:0] window_cnt;  // samples left in the capture window.

  ////////////////////////////////////////////////////////////////////////////
  // arm latch
  ////////////////////////////////////////////////////////////////////////////

  // clearing wins over setting, so a trigger in the arm cycle leaves us disarmed.
  always_ff @(posedge adc_clk) begin
    if (rst) begin
      armed <= 1'b0;
    end else if (trig_in || disarm) begin
      armed <= 1'b0;  // one trigger per arm.
    end else if (arm && !capture_active) begin
      armed <= 1'b1;  // arm is ignored while a capture runs.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // capture window
  ////////////////////////////////////////////////////////////////////////////

  // loaded with CAPTURE_LEN and counted down to zero, so the window is
  // open for CAPTURE_LEN cycles starting the cycle after the trigger.
  always_ff @(posedge adc_clk) begin
    if (rst) begin
      window_cnt <= '0;
    end else if (trig_in) begin
      window_cnt <= CAPTURE_CNT_WIDTH'(CAPTURE_LEN);  // a new trigger restarts the window.
    end else if (window_cnt != '0) begin
      window_cnt <= window_cnt - 1'b1;
    end
  end

  assign capture_active = (window_cnt != '0);  // open while samples remain.

  ////////////////////////////////////////////////////////////////////////////
  // trigger counter
  ////////////////////////////////////////////////////////////////////////////

  // every trigger counts, including bypass triggers that came unarmed.
  always_ff @(posedge adc_clk) begin
    if (rst) begin
      trig_count <= '0;
    end else if (trig_in) begin
      trig_count <= trig_count + 1'b1;  // wraps at the top.
    end
  end

endmodule

// File: src/trigger_top.sv
module trigger_top (
  input  logic                             adc_clk,
  input  logic                             rst,
  input  logic [trig_pkg::NUM_PINS-1:0]    trig_pins,
  input  logic [trig_pkg::ADC_WIDTH-1:0]   adc_data,
  input  trig_pkg::seq_cfg_t               seq_cfg,
  input  trig_pkg::level_cfg_t             level_cfg,
  input  logic                             arm,
  input  logic                             disarm,
  output logic                             trig_out,
  output trig_pkg::trig_status_t           status,
  output logic [trig_pkg::COUNT_WIDTH-1:0] trig_count
);

  import trig_pkg::*;

  logic [NUM_PINS-1:0]     pin_edges;       // synchronized pin rising edges.
  logic                    level_edge;      // ADC threshold crossing.
  logic [NUM_TRIGGERS-1:0] triggers;        // slot ordered trigger vector.
  logic                    armed;           // from the arm latch to the sequencer.
  logic                    capture_active;  // capture window open.
  logic                    fail_early;      // gap shorter than its window.
  logic                    fail_late;       // gap longer than its window.

  ////////////////////////////////////////////////////////////////////////////
  // trigger sources
  ////////////////////////////////////////////////////////////////////////////

  trigger_pin_sync u_pin_sync (
    .adc_clk   (adc_clk),
    .rst       (rst),
    .pins      (trig_pins),
    .pin_edges (pin_edges)
  );

  adc_level_trigger u_level (
    .adc_clk    (adc_clk),
    .rst        (rst),
    .adc_data   (adc_data),
    .cfg        (level_cfg),
    .level_edge (level_edge)
  );

  assign triggers = {level_edge, pin_edges};  // pins on slots 0 to 2, level on slot 3.

  ////////////////////////////////////////////////////////////////////////////
  // sequencing and arm control
  ////////////////////////////////////////////////////////////////////////////

  trigger_sequencer u_seq (
    .adc_clk    (adc_clk),
    .rst        (rst),
    .armed      (armed),
    .triggers   (triggers),
    .cfg        (seq_cfg),
    .trig_out   (trig_out),
    .fail_early (fail_early),
    .fail_late  (fail_late)
  );

  capture_arm_ctrl u_arm (
    .adc_clk        (adc_clk),
    .rst            (rst),
    .arm            (arm),
    .disarm         (disarm),
    .trig_in        (trig_out),
    .armed          (armed),
    .capture_active (capture_active),
    .trig_count     (trig_count)
  );

  // status bundle for the host side.
  assign status = '{armed:          armed,
                    capture_active: capture_active,
                    fail_early:     fail_early,
                    fail_late:      fail_late};

endmodule

// File: sim/trigger_checker.sv
module trigger_checker (
  input  logic                             adc_clk,
  input  logic                             rst,
  input  logic [trig_pkg::NUM_PINS-1:0]    trig_pins,
  input  logic [trig_pkg::ADC_WIDTH-1:0]   adc_data,
  input  trig_pkg::seq_cfg_t               seq_cfg,
  input  trig_pkg::level_cfg_t             level_cfg,
  input  logic                             arm,
  input  logic                             disarm,
  input  logic                             trig_out,
  input  trig_pkg::trig_status_t           status,
  input  logic [trig_pkg::COUNT_WIDTH-1:0] trig_count,
  output int                               err_count
);

  import trig_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // model state, one register per rule in the trigger path
  ////////////////////////////////////////////////////////////////////////////

  logic [NUM_PINS-1:0]      p_s1, p_s2, p_prev, p_edge;  // three flops of pin latency.
  logic                     l_prev, l_edge;              // level crossing model.
  logic [1:0]               m_state;                     // 0 idle, 1 first slot, 2 later slots.
  logic [SLOT_WIDTH-1:0]    m_slot;                      // slot the model expects next.
  logic [COUNTER_WIDTH-1:0] m_cnt;                       // cycles since the last advance.
  logic                     m_armed;                     // model of the arm latch.
  int                       m_win;                       // capture samples still to go.
  logic [COUNT_WIDTH-1:0]   m_count;                     // model trigger count.
  logic                     seen_rst;                    // no compare before the first reset.
  logic [NUM_TRIGGERS-1:0]  m_trig;                      // model trigger vector.
  logic                     l_hit, m_fire, m_early, m_late, m_adv, m_out;
  logic [1:0]               m_next;
  logic [SLOT_WIDTH-1:0]    gi;                          // gap index feeding the expected slot.

  assign m_trig = {l_edge, p_edge};  // slot 3 is the level trigger.
  assign l_hit  = level_cfg.falling ? (adc_data <= level_cfg.threshold)
                                    : (adc_data >= level_cfg.threshold);

  // sequencing rules, evaluated on the current model state.
  always @* begin
    m_fire  = 1'b0;
    m_early = 1'b0;
    m_late  = 1'b0;
    m_adv   = 1'b0;
    m_next  = m_state;
    gi      = (m_slot == 0) ? 2'd0 : m_slot - 2'd1;
    if (!(m_armed && seq_cfg.enable)) begin
      m_next = 2'd0;  // not armed means idle.
    end else if (m_state == 2'd0) begin
      m_next = 2'd1;
    end else if (m_state == 2'd1) begin
      if (m_trig[0]) begin
        m_fire = (seq_cfg.last_slot == 0);  // a single slot sequence ends here.
        m_adv  = !m_fire;
        m_next = m_fire ? 2'd0 : 2'd2;
      end
    end else if (m_trig[m_slot]) begin
      if (m_cnt < seq_cfg.min_wait[gi]) begin
        m_early = 1'b1;
        m_next  = 2'd0;
      end else if (m_slot >= seq_cfg.last_slot) begin
        m_fire = 1'b1;
        m_next = 2'd0;
      end else begin
        m_adv = 1'b1;
      end
    end else if (m_cnt == seq_cfg.max_wait[gi]) begin
      m_late = 1'b1;  // ran out of window with no pulse.
      m_next = 2'd0;
    end
    m_out = seq_cfg.bypass ? m_trig[0] : m_fire;
  end

  ////////////////////////////////////////////////////////////////////////////
  // model registers, stepped on the same edge as the DUT
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk) begin
    if (rst) begin
      {p_s1, p_s2, p_prev, p_edge} <= '0;
      l_prev   <= 1'b1;  // first sample after reset never fires.
      l_edge   <= 1'b0;
      m_state  <= 2'd0;
      m_slot   <= '0;
      m_cnt    <= '0;
      m_armed  <= 1'b0;
      m_win    <= 0;
      m_count  <= '0;
      seen_rst <= 1'b1;
    end else begin
      p_s1    <= trig_pins;
      p_s2    <= p_s1;
      p_prev  <= p_s2;
      p_edge  <= p_s2 & ~p_prev;
      l_prev  <= l_hit;
      l_edge  <= l_hit & ~l_prev;
      m_state <= m_next;
      m_slot  <= (m_state == 2'd0) ? '0 : (m_adv ? m_slot + 1'b1 : m_slot);
      m_cnt   <= m_adv ? '0 : ((m_state == 2'd2) ? m_cnt + 1'b1 : m_cnt);
      if (m_out || disarm) m_armed <= 1'b0;
      else if (arm && m_win == 0) m_armed <= 1'b1;  // arm ignored during capture.
      m_win   <= m_out ? CAPTURE_LEN : ((m_win > 0) ? m_win - 1 : 0);
      m_count <= m_out ? m_count + 1'b1 : m_count;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // comparison on the falling edge, where everything has settled
  ////////////////////////////////////////////////////////////////////////////

  initial err_count = 0;
  initial seen_rst = 1'b0;

  always @(negedge adc_clk) begin
    if (seen_rst) begin
      if (trig_out !== m_out) begin
        $display("MISMATCH at time %0t: trig_out is %b, model %b", $time, trig_out, m_out);
        err_count++;
      end
      if (status !== {m_armed, m_win != 0, m_early & ~seq_cfg.bypass,
                      m_late & ~seq_cfg.bypass}) begin
        $display("MISMATCH at time %0t: status is %b, model armed %b capture %b early %b late %b",
                 $time, status, m_armed, m_win != 0, m_early, m_late);
        err_count++;
      end
      if (trig_count !== m_count) begin
        $display("MISMATCH at time %0t: trig_count is %0d, model %0d", $time, trig_count, m_count);
        err_count++;
      end
    end
  end

endmodule

// File: sim/tb_trigger_top.sv
module tb_trigger_top;

  import trig_pkg::*;

  // planned cycles per test plus 20 percent for the watchdog.
  localparam int PLAN_CYCLES = 220 + 300 + 1400 + 800 + 950 + 450;
  localparam int LIMIT       = PLAN_CYCLES * 12 / 10;

  logic                   adc_clk, rst, arm, disarm, trig_out;
  logic [NUM_PINS-1:0]    trig_pins;
  logic [ADC_WIDTH-1:0]   adc_data;
  seq_cfg_t               seq_cfg;
  level_cfg_t             level_cfg;
  trig_status_t           status;
  logic [COUNT_WIDTH-1:0] trig_count, start_count;
  logic [15:0]            lfsr_state = 16'd38266;  // fixed seed.
  int                     chk_errors, start_errors, local_errors;
  int                     cycles = 0, pass_tests = 0, fail_tests = 0;

  trigger_top u_dut (.adc_clk(adc_clk), .rst(rst), .trig_pins(trig_pins), .adc_data(adc_data),
    .seq_cfg(seq_cfg), .level_cfg(level_cfg), .arm(arm), .disarm(disarm),
    .trig_out(trig_out), .status(status), .trig_count(trig_count));

  trigger_checker u_chk (.adc_clk(adc_clk), .rst(rst), .trig_pins(trig_pins),
    .adc_data(adc_data), .seq_cfg(seq_cfg), .level_cfg(level_cfg), .arm(arm),
    .disarm(disarm), .trig_out(trig_out), .status(status), .trig_count(trig_count),
    .err_count(chk_errors));

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;  // period of 10.
  end

  always @(posedge adc_clk) cycles++;

  initial begin
    wait (cycles >= LIMIT);
    $display("timeout: the run did not finish within %0d cycles", LIMIT);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random numbers and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // taps 16, 14, 13, 11.
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit taken.
      v = (v << 1) | lfsr_state[0];
    end
    return v;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + rand_bits(12) % (hi - lo + 1);
  endfunction

  task automatic tick();
    @(posedge adc_clk);
    #1;  // inputs change just after the edge.
  endtask

  // a sample on the side of the threshold that cannot fire.
  task automatic quiet_sample();
    if (level_cfg.falling) adc_data = rand_range(level_cfg.threshold + 1, 4095);
    else adc_data = rand_range(0, level_cfg.threshold - 1);
  endtask

  task automatic wait_quiet(input int n);
    repeat (n) begin
      quiet_sample();
      tick();
    end
  endtask

  task automatic pulse_pin(input int i);
    trig_pins[i] = 1'b1;
    tick();
    trig_pins[i] = 1'b0;
  endtask

  task automatic pulse_ctrl(input bit is_arm);
    if (is_arm) arm = 1'b1;
    else disarm = 1'b1;
    tick();
    arm    = 1'b0;
    disarm = 1'b0;
  endtask

  task automatic random_windows(input int last);
    for (int g = 0; g < NUM_TRIGGERS - 1; g++) begin
      seq_cfg.min_wait[g] = rand_range(2, 9);
      seq_cfg.max_wait[g] = seq_cfg.min_wait[g] + rand_range(3, 10);
    end
    seq_cfg.last_slot = last;
  endtask

  // mode 0 runs a valid sequence, 1 makes gap 0 too short, 2 lets gap 0 expire.
  task automatic run_sequence(input int last, input int mode);
    int d;
    pulse_pin(0);
    for (int s = 1; s <= last; s++) begin
      if (mode == 2) begin
        wait_quiet(seq_cfg.max_wait[0] + 4);  // past the late point.
        return;
      end
      d = (mode == 1) ? seq_cfg.min_wait[0]
                      : seq_cfg.min_wait[s-1] + 1 + rand_range(0, seq_cfg.max_wait[s-1] -
                                                                  seq_cfg.min_wait[s-1]);
      if (s == 3) begin
        wait_quiet(d + 1);  // the level path is two cycles shorter than a pin.
        adc_data = level_cfg.falling ? rand_range(0, level_cfg.threshold)
                                     : rand_range(level_cfg.threshold, 4095);
        tick();
        quiet_sample();
      end else begin
        wait_quiet(d - 1);
        pulse_pin(s);
      end
      if (mode == 1) return;
    end
  endtask

  task automatic begin_test();
    start_errors = chk_errors;
    start_count  = trig_count;
    local_errors = 0;
  endtask

  task automatic end_test(input string name, input int exp_delta);
    int errs;
    if (COUNT_WIDTH'(trig_count - start_count) != COUNT_WIDTH'(exp_delta)) begin
      $display("MISMATCH at time %0t: %s expected %0d triggers, got %0d", $time, name,
               exp_delta, COUNT_WIDTH'(trig_count - start_count));
      local_errors++;
    end
    errs = chk_errors - start_errors + local_errors;
    if (errs == 0) pass_tests++;
    else fail_tests++;
    $display("test %s: %s (%0d errors)", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst = 1'b1;
    arm = 1'b0;
    disarm = 1'b0;
    trig_pins = '0;
    adc_data = '0;
    seq_cfg = '0;
    level_cfg = '{threshold: 12'd2048, falling: 1'b0};
    repeat (3) tick();  // reset held for three cycles.
    rst = 1'b0;

    begin_test();  // nothing may come out while unarmed.
    seq_cfg.enable = 1'b1;
    repeat (200) begin
      trig_pins = rand_bits(NUM_PINS);
      adc_data  = rand_bits(ADC_WIDTH);
      tick();
    end
    trig_pins = '0;
    wait_quiet(6);
    end_test("reset_state", 0);

    begin_test();
    seq_cfg.bypass = 1'b1;
    repeat (25) begin
      pulse_pin(0);
      wait_quiet(rand_range(2, 9));
    end
    wait_quiet(70);  // bypass triggers open capture windows too.
    seq_cfg.bypass = 1'b0;
    end_test("bypass", 25);

    begin_test();
    for (int last = 1; last <= 3; last++) begin
      repeat (3) begin
        random_windows(last);
        pulse_ctrl(1);
        wait_quiet(3);
        run_sequence(last, 0);
        wait_quiet(70);  // let the capture window close.
      end
    end
    end_test("in_window", 9);

    begin_test();
    for (int mode = 1; mode <= 2; mode++) begin
      repeat (2) begin
        random_windows(rand_range(1, 3));
        pulse_ctrl(1);
        wait_quiet(3);
        run_sequence(seq_cfg.last_slot, mode);
        wait_quiet(6);
        run_sequence(seq_cfg.last_slot, 0);  // still armed, this one fires.
        wait_quiet(70);
      end
    end
    end_test("window_violation", 4);

    begin_test();
    for (int pol = 0; pol < 2; pol++) begin
      repeat (3) begin
        level_cfg = '{threshold: rand_range(256, 3839), falling: pol[0]};
        wait_quiet(4);
        random_windows(3);
        pulse_ctrl(1);
        wait_quiet(3);
        run_sequence(3, 0);
        wait_quiet(70);
      end
    end
    end_test("level_trigger", 6);

    begin_test();
    random_windows(2);
    pulse_ctrl(1);
    wait_quiet(3);
    pulse_pin(0);
    wait_quiet(4);
    pulse_ctrl(0);  // disarm in the middle of the sequence.
    wait_quiet(4);
    run_sequence(2, 0);
    pulse_ctrl(1);
    wait_quiet(3);
    run_sequence(2, 0);
    wait_quiet(6);
    pulse_ctrl(1);  // lands in the capture window and must be ignored.
    wait_quiet(3);
    run_sequence(2, 0);
    wait_quiet(70);
    end_test("disarm_rearm", 1);

    $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
src/trig_pkg.sv
src/trigger_pin_sync.sv
src/adc_level_trigger.sv
src/trigger_sequencer.sv
src/capture_arm_ctrl.sv
src/trigger_top.sv
sim/trigger_checker.sv
sim/tb_trigger_top.sv
